//--- common/rom_bank_pkg.sv
// Shared constants and the bank word type for the ROM fetch layer, imported by every design file
package rom_bank_pkg;

    // Bank port widths
    localparam int BA_AW  = 22;
    localparam int BA_DW  = 16;

    // One cache line holds an even/odd pair of bank words
    localparam int LINE_W = 32;

    // Region start addresses, in bank words
    localparam logic [BA_AW-1:0] MAIN_BASE = 22'h000000;
    localparam logic [BA_AW-1:0] SND_BASE  = 22'h200000;
    localparam logic [BA_AW-1:0] GFX_BASE  = 22'h100000;

    // Client count and slot indices
    // Lower index wins arbitration
    localparam int N_SLOTS  = 3;
    localparam int GFX_IDX  = 0;
    localparam int MAIN_IDX = 1;
    localparam int SND_IDX  = 2;

    // Arbiter FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    // One bank word, seen as a half word or as two bytes
    // The hi byte sits at the odd byte address
    typedef union packed {
        logic [BA_DW-1:0] half;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } sdram_word_u;

endpackage

//--- common/slot_bus_if.sv
// Request and answer bundle between one ROM slot and the bank arbiter
`timescale 1ns/10ps

interface slot_bus_if;
    import rom_bank_pkg::*;

    // Slot side, held until rdy
    logic             req;
    logic [BA_AW-1:0] addr;

    // Arbiter side, only active for the granted slot
    logic             ack;
    logic             dok;
    logic             rdy;
    logic [BA_DW-1:0] data;

    modport slot (
        output req,
        output addr,
        input  ack,
        input  dok,
        input  rdy,
        input  data
    );

    modport arb (
        input  req,
        input  addr,
        output ack,
        output dok,
        output rdy,
        output data
    );

endinterface

//--- rtl/rom_slot.sv
// ROM client slot with a one-line cache, fetching missed lines as two-word bank bursts
`timescale 1ns/10ps

module rom_slot #(
    parameter int DW = 16,
    parameter int AW = 21
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cs,
    input  logic [AW-1:0]                  addr,
    input  logic [rom_bank_pkg::BA_AW-1:0] base,
    output logic [DW-1:0]                  data,
    output logic                           ok,
    slot_bus_if.slot                       bus
);
    import rom_bank_pkg::*;

    // Even bank word address of the line that addr falls in
    logic [BA_AW-1:0] line_ba;
    logic [DW-1:0]    sel_data;
    logic             hit;
    logic             start;

    // Cache line state
    logic             valid;
    logic [BA_AW-1:0] tag;
    sdram_word_u      line_w [2];

    // Burst word pointer
    logic             word_sel;
    logic             wsel;

    // Registered answer
    logic             ok_q;
    logic [AW-1:0]    addr_q;
    logic [DW-1:0]    data_q;

    generate
        if (DW == 32) begin : g_w32
            // addr counts 32-bit units, one per line
            assign line_ba  = base + BA_AW'({addr, 1'b0});
            assign sel_data = {line_w[1].half, line_w[0].half};
        end else if (DW == 16) begin : g_w16
            // addr[0] is byte address bit 1
            assign line_ba  = base + BA_AW'({addr[AW-1:1], 1'b0});
            assign sel_data = addr[0] ? line_w[1].half : line_w[0].half;
        end else begin : g_w8
            sdram_word_u cur_w;

            assign line_ba  = base + BA_AW'({addr[AW-1:2], 1'b0});
            assign cur_w    = addr[1] ? line_w[1] : line_w[0];
            // Odd bytes come from the upper half
            assign sel_data = addr[0] ? cur_w.bytes.hi : cur_w.bytes.lo;
        end
    endgenerate

    assign hit   = valid && (tag == line_ba);
    assign start = cs && !hit && !bus.req;

    // Request address is the tag of the line being filled
    assign bus.addr = tag;

    // Restart at the even word once the burst is accepted
    assign wsel = bus.ack ? 1'b0 : word_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.req  <= 1'b0;
            valid    <= 1'b0;
            word_sel <= 1'b0;
            ok_q     <= 1'b0;
        end else begin
            ok_q     <= cs && hit;
            word_sel <= wsel ^ bus.dok;
            if (start) begin
                // Old contents are being overwritten
                bus.req <= 1'b1;
                valid   <= 1'b0;
            end else if (bus.rdy) begin
                bus.req <= 1'b0;
                valid   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tag <= line_ba;
        end
        if (bus.dok) begin
            line_w[wsel].half <= bus.data;
        end
        addr_q <= addr;
        data_q <= sel_data;
    end

    // Drop ok as soon as the client moves away from the answered address
    assign ok   = ok_q && cs && (addr == addr_q);
    assign data = data_q;

    // Client keeps its address until the line arrives
    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.req |-> $stable(addr)
    );

    // Requests always start on an even bank word
    a_req_even: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.req |-> !bus.addr[0]
    );

endmodule

//--- rtl/bank_arbiter.sv
// Fixed-priority arbiter that gives the SDRAM bank port to one ROM slot per burst
`timescale 1ns/10ps

module bank_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    slot_bus_if.arb                        slots [rom_bank_pkg::N_SLOTS],
    output logic [rom_bank_pkg::BA_AW-1:0] ba_addr,
    output logic                           ba_rd,
    input  logic                           ba_ack,
    input  logic                           ba_dok,
    input  logic                           ba_rdy,
    input  logic [rom_bank_pkg::BA_DW-1:0] data_read
);
    import rom_bank_pkg::*;

    logic [1:0]         state;
    logic [N_SLOTS-1:0] grant;
    logic [N_SLOTS-1:0] req_vec;
    logic [N_SLOTS-1:0] pick;
    logic [BA_AW-1:0]   slot_addr [N_SLOTS];
    logic [BA_AW-1:0]   pick_addr;

    // Gather requests, return answers only to the granted slot
    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        assign req_vec[i]    = slots[i].req;
        assign slot_addr[i]  = slots[i].addr;
        assign slots[i].ack  = grant[i] & ba_ack;
        assign slots[i].dok  = grant[i] & ba_dok;
        assign slots[i].rdy  = grant[i] & ba_rdy;
        assign slots[i].data = grant[i] ? data_read : '0;
    end

    // Graphics first, then main CPU, then sound CPU
    always_comb begin
        pick = '0;
        if (req_vec[GFX_IDX]) begin
            pick[GFX_IDX] = 1'b1;
        end else if (req_vec[MAIN_IDX]) begin
            pick[MAIN_IDX] = 1'b1;
        end else if (req_vec[SND_IDX]) begin
            pick[SND_IDX] = 1'b1;
        end
    end

    always_comb begin
        pick_addr = '0;
        for (int i = 0; i < N_SLOTS; i++) begin
            if (pick[i]) begin
                pick_addr = slot_addr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            grant <= '0;
            ba_rd <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|req_vec) begin
                        grant <= pick;
                        ba_rd <= 1'b1;
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Controller took the address
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // Second word arrives with rdy
                    if (ba_rdy) begin
                        grant <= '0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    grant <= '0;
                    ba_rd <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && |req_vec) begin
            ba_addr <= pick_addr;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant)
    );

    // Read request and address hold until the controller accepts them
    a_rd_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr)
    );

    // No data may come back without an open burst
    a_no_idle_dok: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == ST_IDLE |-> !ba_dok
    );

endmodule

//--- rtl/cps_rom_bank.sv
// ROM fetch top level, joining the main, sound and graphics clients onto one SDRAM bank port
`timescale 1ns/10ps

module cps_rom_bank (
    input  logic                           clk,
    input  logic                           rst_n,
    // Main CPU program ROM, 16-bit words
    input  logic                           main_cs,
    input  logic [21:1]                    main_addr,
    output logic [15:0]                    main_data,
    output logic                           main_ok,
    // Sound CPU ROM, bytes
    input  logic                           snd_cs,
    input  logic [18:0]                    snd_addr,
    output logic [ 7:0]                    snd_data,
    output logic                           snd_ok,
    // Graphics ROM, 32-bit words
    input  logic                           gfx_cs,
    input  logic [19:0]                    gfx_addr,
    output logic [31:0]                    gfx_data,
    output logic                           gfx_ok,
    // SDRAM bank port
    output logic [rom_bank_pkg::BA_AW-1:0] ba_addr,
    output logic                           ba_rd,
    input  logic                           ba_ack,
    input  logic                           ba_dok,
    input  logic                           ba_rdy,
    input  logic [rom_bank_pkg::BA_DW-1:0] data_read
);
    import rom_bank_pkg::*;

    slot_bus_if slot_bus [N_SLOTS] ();

    rom_slot #(.DW(32), .AW(20)) u_gfx_slot (
        .clk        ( clk                  ),
        .rst_n      ( rst_n                ),
        .cs         ( gfx_cs               ),
        .addr       ( gfx_addr             ),
        .base       ( GFX_BASE             ),
        .data       ( gfx_data             ),
        .ok         ( gfx_ok               ),
        .bus        ( slot_bus[GFX_IDX]    )
    );

    rom_slot #(.DW(16), .AW(21)) u_main_slot (
        .clk        ( clk                  ),
        .rst_n      ( rst_n                ),
        .cs         ( main_cs              ),
        .addr       ( main_addr            ),
        .base       ( MAIN_BASE            ),
        .data       ( main_data            ),
        .ok         ( main_ok              ),
        .bus        ( slot_bus[MAIN_IDX]   )
    );

    rom_slot #(.DW(8), .AW(19)) u_snd_slot (
        .clk        ( clk                  ),
        .rst_n      ( rst_n                ),
        .cs         ( snd_cs               ),
        .addr       ( snd_addr             ),
        .base       ( SND_BASE             ),
        .data       ( snd_data             ),
        .ok         ( snd_ok               ),
        .bus        ( slot_bus[SND_IDX]    )
    );

    bank_arbiter u_arbiter (
        .clk        ( clk                  ),
        .rst_n      ( rst_n                ),
        .slots      ( slot_bus             ),
        .ba_addr    ( ba_addr              ),
        .ba_rd      ( ba_rd                ),
        .ba_ack     ( ba_ack               ),
        .ba_dok     ( ba_dok               ),
        .ba_rdy     ( ba_rdy               ),
        .data_read  ( data_read            )
    );

endmodule

//--- sim/rom_bank_checker.sv
// Testbench checker that watches the ROM clients and the bank port, compares data and counts errors
`timescale 1ns/10ps

module rom_bank_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           main_cs,
    input  logic [21:1]                    main_addr,
    input  logic [15:0]                    main_data,
    input  logic                           main_ok,
    input  logic                           snd_cs,
    input  logic [18:0]                    snd_addr,
    input  logic [ 7:0]                    snd_data,
    input  logic                           snd_ok,
    input  logic                           gfx_cs,
    input  logic [19:0]                    gfx_addr,
    input  logic [31:0]                    gfx_data,
    input  logic                           gfx_ok,
    input  logic                           ba_rd,
    input  logic                           ba_dok,
    input  logic                           ba_rdy,
    output int                             data_errs,
    output int                             ctrl_errs,
    output int                             n_checks
);
    import rom_bank_pkg::*;

    string test_name = "none";
    int    n_data    = 0;
    int    n_ctrl    = 0;
    int    n_cmp     = 0;
    // Burst bookkeeping
    int    n_rd      = 0;
    int    n_rdy     = 0;
    logic  rd_q      = 1'b0;

    assign data_errs = n_data;
    assign ctrl_errs = n_ctrl;
    assign n_checks  = n_cmp;

    // ROM contents as the SDRAM model holds them
    function automatic logic [15:0] mem_word(input logic [BA_AW-1:0] ba);
        return ba[15:0] ^ 16'h5a3c;
    endfunction

    task automatic compare(input string client, input logic [31:0] addr,
                           input logic [31:0] exp, input logic [31:0] act);
        n_cmp++;
        if (exp !== act) begin
            n_data++;
            $display("ERR %s: %s addr %h expected %h actual %h",
                     test_name, client, addr, exp, act);
        end
    endtask

    task automatic ctrl_error(input string what);
        n_ctrl++;
        $display("Test %s at %0t: %s", test_name, $time, what);
    endtask

    always @(posedge clk) begin : watch
        logic [BA_AW-1:0] ba;
        logic [15:0]      w;
        if (!rst_n) begin
            if (main_ok || snd_ok || gfx_ok || ba_rd) begin
                ctrl_error("an ok output or ba_rd is high during reset");
            end
        end else begin
            if (main_cs && main_ok) begin
                ba = MAIN_BASE + BA_AW'(main_addr);
                compare("main", 32'(main_addr), 32'(mem_word(ba)), 32'(main_data));
            end
            if (snd_cs && snd_ok) begin
                ba = SND_BASE + BA_AW'(snd_addr[18:1]);
                w  = mem_word(ba);
                // Odd byte address reads the upper byte
                compare("snd", 32'(snd_addr), snd_addr[0] ? 32'(w[15:8]) : 32'(w[7:0]),
                        32'(snd_data));
            end
            if (gfx_cs && gfx_ok) begin
                ba = GFX_BASE + BA_AW'({gfx_addr, 1'b0});
                compare("gfx", 32'(gfx_addr),
                        {mem_word({ba[BA_AW-1:1], 1'b1}), mem_word(ba)}, gfx_data);
            end
            // One burst open at a time
            if (ba_rd && !rd_q) begin
                if (n_rd != n_rdy) begin
                    ctrl_error("a new ba_rd request started while a burst was still open");
                end
                n_rd++;
            end
            if (ba_dok && n_rd == n_rdy) begin
                ctrl_error("ba_dok arrived with no burst open");
            end
            if (ba_rdy) begin
                if (n_rd != n_rdy + 1) begin
                    ctrl_error("ba_rdy arrived with no burst open");
                end
                n_rdy++;
            end
        end
        rd_q = ba_rd;
    end

endmodule

//--- sim/tb_cps_rom_bank.sv
// Testbench top for the ROM fetch layer with an SDRAM model and client traffic, run by run_sim.sh
`timescale 1ns/10ps

module tb_cps_rom_bank;
    import rom_bank_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_MAIN     = 20;
    localparam int N_HIT      = 4;
    localparam int N_LINES    = 6;
    localparam int N_GFX      = 10;
    localparam int N_ROUNDS   = 8;
    // Grant, ack delay, two gaps, two words and the ok register
    localparam int BURST_CYC  = 20;
    localparam int ACC_TMO    = N_SLOTS * BURST_CYC;
    localparam int N_ACC      = 1 + N_MAIN + 2 * N_HIT + 4 * N_LINES + N_GFX + N_SLOTS * N_ROUNDS;
    localparam int WD_CYCLES  = 8 + N_ACC * ACC_TMO;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             main_cs;
    logic [21:1]      main_addr;
    logic [15:0]      main_data;
    logic             main_ok;
    logic             snd_cs;
    logic [18:0]      snd_addr;
    logic [ 7:0]      snd_data;
    logic             snd_ok;
    logic             gfx_cs;
    logic [19:0]      gfx_addr;
    logic [31:0]      gfx_data;
    logic             gfx_ok;
    logic [BA_AW-1:0] ba_addr;
    logic             ba_rd;
    logic             ba_ack;
    logic             ba_dok;
    logic             ba_rdy;
    logic [BA_DW-1:0] data_read;
    int               data_errs;
    int               ctrl_errs;
    int               n_checks;
    int               timing_errs = 0;
    int unsigned      seed;

    cps_rom_bank u_cps_rom_bank (.*);

    rom_bank_checker u_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // SDRAM bank model, one two-word burst per request
    initial begin : sdram_model
        logic [BA_AW-1:0] burst_addr;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (ba_rd) begin
                burst_addr = ba_addr;
                repeat ($urandom_range(6, 1) - 1) @(negedge clk);
                ba_ack = 1'b1;
                @(negedge clk);
                ba_ack = 1'b0;
                repeat ($urandom_range(3, 0)) @(negedge clk);
                ba_dok    = 1'b1;
                data_read = u_checker.mem_word(burst_addr);
                @(negedge clk);
                ba_dok = 1'b0;
                repeat ($urandom_range(3, 0)) @(negedge clk);
                ba_dok    = 1'b1;
                ba_rdy    = 1'b1;
                data_read = u_checker.mem_word({burst_addr[BA_AW-1:1], 1'b1});
                @(negedge clk);
                ba_dok = 1'b0;
                ba_rdy = 1'b0;
            end
        end
    end

    task automatic read_main(input logic [21:1] a, output int cyc);
        main_cs   = 1'b1;
        main_addr = a;
        cyc       = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!main_ok && cyc < ACC_TMO);
        if (!main_ok) begin
            $display("Main read of %h got no ok within %0d cycles", a, ACC_TMO);
            timing_errs++;
        end
    endtask

    task automatic read_snd(input logic [18:0] a, output int cyc);
        snd_cs   = 1'b1;
        snd_addr = a;
        cyc      = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!snd_ok && cyc < ACC_TMO);
        if (!snd_ok) begin
            $display("Sound read of %h got no ok within %0d cycles", a, ACC_TMO);
            timing_errs++;
        end
    endtask

    task automatic read_gfx(input logic [19:0] a, output int cyc);
        gfx_cs   = 1'b1;
        gfx_addr = a;
        cyc      = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!gfx_ok && cyc < ACC_TMO);
        if (!gfx_ok) begin
            $display("Graphics read of %h got no ok within %0d cycles", a, ACC_TMO);
            timing_errs++;
        end
    endtask

    // A cached access answers after one edge with the bank port quiet
    task automatic check_hit(input int cyc);
        if (cyc != 1) begin
            $display("ERR %s: hit latency expected 1 actual %0d", u_checker.test_name, cyc);
            timing_errs++;
        end
        // A request raised on the hit reaches ba_rd one edge later
        @(negedge clk);
        if (ba_rd) begin
            $display("Test %s: a cached access started a bank read", u_checker.test_name);
            timing_errs++;
        end
    endtask

    initial begin : stimulus
        logic [21:1] ma;
        logic [18:0] sa;
        int          lat;
        int          lat_m;
        int          lat_s;
        int          lat_g;
        rst_n     = 1'b0;
        // Clients already selected during reset must still see no ok
        main_cs   = 1'b1;
        main_addr = '0;
        snd_cs    = 1'b1;
        snd_addr  = '0;
        gfx_cs    = 1'b1;
        gfx_addr  = '0;
        seed      = $urandom(32'hd742_6070);
        u_checker.test_name = "reset";
        repeat (8) @(negedge clk);
        rst_n   = 1'b1;
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        gfx_cs  = 1'b0;
        @(negedge clk);

        u_checker.test_name = "first_miss";
        read_main(21'h000100, lat);
        if (lat < 3) begin
            $display("First access after reset finished in %0d cycles, too fast for a miss", lat);
            timing_errs++;
        end

        u_checker.test_name = "main_rand";
        repeat (N_MAIN) read_main(21'($urandom()), lat);

        u_checker.test_name = "cache_hit";
        for (int i = 0; i < N_HIT; i++) begin
            ma = 21'($urandom()) & ~21'd1;
            read_main(ma, lat);
            read_main(ma | 21'd1, lat);
            check_hit(lat);
        end

        // All four byte offsets of each line, the last three from the cache
        u_checker.test_name = "snd_bytes";
        for (int i = 0; i < N_LINES; i++) begin
            sa = 19'($urandom()) & ~19'd3;
            for (int off = 0; off < 4; off++) begin
                read_snd(sa | 19'(off), lat);
                if (off > 0) begin
                    check_hit(lat);
                end
            end
        end

        u_checker.test_name = "gfx_rand";
        repeat (N_GFX) read_gfx(20'($urandom()), lat);

        u_checker.test_name = "contention";
        for (int r = 0; r < N_ROUNDS; r++) begin
            fork
                read_main(21'($urandom()), lat_m);
                read_snd(19'($urandom()), lat_s);
                read_gfx(20'($urandom()), lat_g);
            join
        end
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        gfx_cs  = 1'b0;
        repeat (4) @(negedge clk);

        $display("Error counts: data %0d, control %0d, timing %0d, over %0d data checks",
                 data_errs, ctrl_errs, timing_errs, n_checks);
        if (data_errs + ctrl_errs + timing_errs == 0 && n_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            if (n_checks == 0) begin
                $display("No client data was ever compared");
            end
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WD_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- cps_rom_bank.f
common/rom_bank_pkg.sv
common/slot_bus_if.sv
rtl/rom_slot.sv
rtl/bank_arbiter.sv
rtl/cps_rom_bank.sv
sim/rom_bank_checker.sv
sim/tb_cps_rom_bank.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the ROM fetch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cps_rom_bank \
    -f cps_rom_bank.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
